/* design/mem_map_pkg.sv */
package mem_map_pkg;

  ////////////////////
  // Address map
  ////////////////////

  // RAM region base, offsets inside the mask select the word
  localparam logic [31:0] RAM_BASE_ADDR = 32'h4000_0000;
  localparam logic [31:0] RAM_MASK_ADDR = 32'h000f_ffff;

  // Cycle timer words, exact match only
  localparam logic [31:0] TIMER_LO_ADDR = 32'h3000_0000;
  localparam logic [31:0] TIMER_HI_ADDR = 32'h3000_0004;

  ////////////////////
  // RAM sizing
  ////////////////////

  // Number of 32-bit words in the main RAM
  localparam int unsigned RAM_WORDS = 4096;

  // Word index width
  localparam int unsigned RAM_AW = $clog2(RAM_WORDS);

  // Cycles from request start to ready pulse
  // Models slow external memory
  localparam int unsigned RAM_DELAY = 16;

endpackage

/* design/iomem_pkg.sv */
package iomem_pkg;

  ////////////////////
  // Bus payload
  ////////////////////

  // Address and data word of the memory bus
  typedef logic [31:0] word_t;

  // Byte write strobe, bit n enables lane n
  // All zeros marks a read
  typedef logic [3:0] strb_t;

  ////////////////////
  // Decoded target
  ////////////////////

  typedef enum logic [1:0] {
    REG_NONE     = 2'd0,
    REG_RAM      = 2'd1,
    REG_TIMER_LO = 2'd2,
    REG_TIMER_HI = 2'd3
  } region_e;

endpackage

/* design/iomem_req_if.sv */
`timescale 1ns/1ps

// Decoded request as seen by the RAM and the response unit
interface iomem_req_if
  import iomem_pkg::*;
();

  // Request level from the master
  logic    valid;

  // Payload, held stable while valid is high
  strb_t   wstrb;
  word_t   addr;
  word_t   wdata;

  // Target chosen by the decoder
  region_e region;

  // Decoder drives everything
  modport decode (
    output valid,
    output wstrb,
    output addr,
    output wdata,
    output region
  );

  // RAM needs the full request
  modport ram (
    input valid,
    input wstrb,
    input addr,
    input wdata,
    input region
  );

  // Response selection only looks at the target
  modport result (
    input valid,
    input region
  );

endinterface

/* design/addr_decoder.sv */
`timescale 1ns/1ps

module addr_decoder
  import iomem_pkg::*, mem_map_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n,

  input  logic  valid_i,
  input  strb_t wstrb_i,
  input  word_t addr_i,
  input  word_t wdata_i,

  iomem_req_if.decode req,

  output logic  first_o
);

  logic    valid_q;
  region_e region;

  ////////////////////
  // Region decode
  ////////////////////

  always_comb begin
    if ((addr_i & ~RAM_MASK_ADDR) == RAM_BASE_ADDR) begin
      region = REG_RAM;
    end else if (addr_i == TIMER_LO_ADDR) begin
      region = REG_TIMER_LO;
    end else if (addr_i == TIMER_HI_ADDR) begin
      region = REG_TIMER_HI;
    end else begin
      region = REG_NONE;
    end
  end

  // Fields pass straight through
  assign req.valid  = valid_i;
  assign req.wstrb  = wstrb_i;
  assign req.addr   = addr_i;
  assign req.wdata  = wdata_i;
  assign req.region = region;

  ////////////////////
  // Start detect
  ////////////////////

  // Last cycle's valid, so a rising level marks a new request
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  assign first_o = valid_i & ~valid_q;

endmodule

/* design/latency_ram.sv */
`timescale 1ns/1ps

module latency_ram
  import iomem_pkg::*, mem_map_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n,

  iomem_req_if.ram req,

  input  logic  start_i,

  output logic  ready_o,
  output word_t rdata_o
);

  // Byte-lane storage, one row per word
  logic [3:0][7:0]      mem_q [RAM_WORDS];

  // Travelling token, its arrival at the top marks ready
  logic [RAM_DELAY-1:0] shift_q;

  // Request captured at start
  logic [RAM_AW-1:0]    idx_q;
  strb_t                strb_q;
  word_t                rdata_q;

  logic [RAM_AW-1:0]    idx;
  logic                 pending;
  logic                 ram_start;

  ////////////////////
  // Request start
  ////////////////////

  // Word index drops the byte offset, upper offset bits alias
  assign idx = req.addr[RAM_AW+1:2];

  // Access in flight while the token is anywhere in the chain
  assign pending = |shift_q;

  assign ram_start = start_i & req.valid & (req.region == REG_RAM) & ~pending;

  ////////////////////
  // Delay line
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      shift_q <= '0;
    end else begin
      shift_q <= {shift_q[RAM_DELAY-2:0], ram_start};
    end
  end

  // Token reaches the last stage RAM_DELAY cycles after start
  assign ready_o = shift_q[RAM_DELAY-1];

  ////////////////////
  // Storage
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (ram_start) begin
      idx_q   <= idx;
      strb_q  <= req.wstrb;
      rdata_q <= mem_q[idx];
    end

    // Commit on the ready edge, master still holds wdata
    if (ready_o) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (strb_q[lane]) begin
          mem_q[idx_q][lane] <= req.wdata[lane*8 +: 8];
        end
      end
    end
  end

  // Read word stays put until the next start
  assign rdata_o = rdata_q;

endmodule

/* design/response_unit.sv */
`timescale 1ns/1ps

module response_unit
  import iomem_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n,

  iomem_req_if.result req,

  input  logic  ram_ready_i,
  input  word_t ram_rdata_i,

  output logic  ready_o,
  output word_t rdata_o
);

  logic [63:0] timer_q;
  logic        fast_hit;

  ////////////////////
  // Cycle timer
  ////////////////////

  // Free running, zero in the first cycle out of reset
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      timer_q <= '0;
    end else begin
      timer_q <= timer_q + 64'd1;
    end
  end

  ////////////////////
  // Ready
  ////////////////////

  // Timer and unmapped space answer at once
  assign fast_hit = req.valid & (req.region != REG_RAM);

  assign ready_o = ram_ready_i | fast_hit;

  ////////////////////
  // Read data
  ////////////////////

  always_comb begin
    case (req.region)
      REG_RAM:      rdata_o = ram_rdata_i;
      REG_TIMER_LO: rdata_o = timer_q[31:0];
      REG_TIMER_HI: rdata_o = timer_q[63:32];
      // Unmapped reads come back as zero
      default:      rdata_o = '0;
    endcase
  end

endmodule

/* design/iomem_fabric_top.sv */
`timescale 1ns/1ps

module iomem_fabric_top
  import iomem_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n,

  // Master request
  input  logic  mem_valid_i,
  input  strb_t mem_wstrb_i,
  input  word_t mem_addr_i,
  input  word_t mem_wdata_i,

  // Response to master
  output logic  mem_ready_o,
  output word_t mem_rdata_o
);

  logic  first;
  logic  ram_ready;
  word_t ram_rdata;

  iomem_req_if req_if ();

  ////////////////////
  // Decode
  ////////////////////

  addr_decoder u_decoder (
    .clk_i   (clk_i),
    .rst_n   (rst_n),
    .valid_i (mem_valid_i),
    .wstrb_i (mem_wstrb_i),
    .addr_i  (mem_addr_i),
    .wdata_i (mem_wdata_i),
    .req     (req_if.decode),
    .first_o (first)
  );

  ////////////////////
  // RAM and response
  ////////////////////

  latency_ram u_ram (
    .clk_i   (clk_i),
    .rst_n   (rst_n),
    .req     (req_if.ram),
    .start_i (first),
    .ready_o (ram_ready),
    .rdata_o (ram_rdata)
  );

  response_unit u_resp (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .req         (req_if.result),
    .ram_ready_i (ram_ready),
    .ram_rdata_i (ram_rdata),
    .ready_o     (mem_ready_o),
    .rdata_o     (mem_rdata_o)
  );

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 40 ns period
  localparam int HALF_PERIOD = 20;

  // Reset length in clock cycles
  localparam int RESET_CYCLES = 3;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Release a little after the edge, like the other inputs
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2;
    rst_n_o = 1'b1;
  end

endmodule

/* verif/iomem_fabric_chk.sv */
`timescale 1ns/1ps

module iomem_fabric_chk
  import iomem_pkg::*, mem_map_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n,
  input  logic  valid_i,
  input  strb_t wstrb_i,
  input  word_t addr_i,
  input  word_t wdata_i,
  input  logic  ready_i,
  input  word_t rdata_i
);

  // Shadow RAM, plus a mark for words written in full at least once
  word_t                shadow_q [RAM_WORDS];
  logic [RAM_WORDS-1:0] known_q;

  // Shadow timer, counts from reset release
  logic [63:0]          timer_q;

  // Start-cycle counter and the RAM request in flight
  logic                 busy_q;
  int unsigned          wait_cnt_q;
  logic [RAM_AW-1:0]    idx_q;
  strb_t                strb_q;
  word_t                wdata_q;
  word_t                exp_rdata_q;
  logic                 exp_known_q;

  logic                 valid_q;
  logic                 rst_q;
  logic                 init_q;

  logic [RAM_AW-1:0]    idx;
  logic                 is_ram;
  logic                 is_timer;
  logic                 is_none;
  logic                 start;
  logic                 ram_done;
  logic                 exp_ready;
  word_t                timer_half;

  logic                 err_ready    = 1'b0;
  logic                 err_ram_data = 1'b0;
  logic                 err_timer    = 1'b0;
  logic                 err_unmapped = 1'b0;
  logic                 err_reset    = 1'b0;
  logic                 failed;

  ////////////////////
  // Address map rules
  ////////////////////

  assign idx        = addr_i[RAM_AW+1:2];
  assign is_ram     = (addr_i & ~RAM_MASK_ADDR) == RAM_BASE_ADDR;
  assign is_timer   = (addr_i == TIMER_LO_ADDR) || (addr_i == TIMER_HI_ADDR);
  assign is_none    = !is_ram && !is_timer;
  assign timer_half = (addr_i == TIMER_HI_ADDR) ? timer_q[63:32] : timer_q[31:0];

  assign start      = valid_i && !valid_q;
  assign ram_done   = busy_q && (wait_cnt_q == RAM_DELAY);
  // RAM answers late, everything else at once
  assign exp_ready  = ram_done || (valid_i && !is_ram);

  assign failed     = err_ready | err_ram_data | err_timer | err_unmapped | err_reset;

  ////////////////////
  // Shadow models
  ////////////////////

  always_ff @(posedge clk_i) begin
    rst_q  <= rst_n;
    init_q <= 1'b1;
    if (!rst_n) begin
      valid_q    <= 1'b0;
      busy_q     <= 1'b0;
      wait_cnt_q <= 0;
      timer_q    <= '0;
      known_q    <= '0;
    end else begin
      valid_q <= valid_i;
      timer_q <= timer_q + 64'd1;
      if (start && is_ram && !busy_q) begin
        busy_q      <= 1'b1;
        wait_cnt_q  <= 1;
        idx_q       <= idx;
        strb_q      <= wstrb_i;
        wdata_q     <= wdata_i;
        exp_rdata_q <= shadow_q[idx];
        exp_known_q <= known_q[idx];
      end else if (ram_done) begin
        busy_q     <= 1'b0;
        wait_cnt_q <= 0;
      end else if (busy_q) begin
        wait_cnt_q <= wait_cnt_q + 1;
      end
      if (ram_done && strb_q == 4'hf) begin
        known_q[idx_q] <= 1'b1;
      end
    end
  end

  // Lane merge in the ready cycle
  always_ff @(posedge clk_i) begin
    if (rst_n && ram_done) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (strb_q[lane]) begin
          shadow_q[idx_q][lane*8 +: 8] <= wdata_q[lane*8 +: 8];
        end
      end
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  a_ready: assert property (@(posedge clk_i) disable iff (!rst_n)
    ready_i == exp_ready)
    else begin
      $error("ERROR %0t: ready is %0b, expected %0b", $time, ready_i, exp_ready);
      err_ready = 1'b1;
    end

  a_ram_data: assert property (@(posedge clk_i) disable iff (!rst_n)
    (ram_done && exp_known_q) |-> rdata_i == exp_rdata_q)
    else begin
      $error("ERROR %0t: RAM read %h, expected %h", $time, rdata_i, exp_rdata_q);
      err_ram_data = 1'b1;
    end

  a_timer: assert property (@(posedge clk_i) disable iff (!rst_n)
    (valid_i && is_timer) |-> rdata_i == timer_half)
    else begin
      $error("ERROR %0t: timer read %h, expected %h", $time, rdata_i, timer_half);
      err_timer = 1'b1;
    end

  a_unmapped: assert property (@(posedge clk_i) disable iff (!rst_n)
    (valid_i && is_none) |-> rdata_i == 32'h0)
    else begin
      $error("ERROR %0t: unmapped read %h, expected zero", $time, rdata_i);
      err_unmapped = 1'b1;
    end

  // Quiet in reset and in the first cycle out of it
  a_reset: assert property (@(posedge clk_i)
    ((!rst_n && init_q) || (rst_n && !rst_q)) |-> !ready_i)
    else begin
      $error("ERROR %0t: ready high around reset", $time);
      err_reset = 1'b1;
    end

endmodule

bind iomem_fabric_top iomem_fabric_chk u_chk (
  .clk_i   (clk_i),
  .rst_n   (rst_n),
  .valid_i (mem_valid_i),
  .wstrb_i (mem_wstrb_i),
  .addr_i  (mem_addr_i),
  .wdata_i (mem_wdata_i),
  .ready_i (mem_ready_o),
  .rdata_i (mem_rdata_o)
);

/* verif/iomem_fabric_tb.sv */
`timescale 1ns/1ps

module iomem_fabric_tb
  import iomem_pkg::*, mem_map_pkg::*;
();

  localparam int          NUM_WORDS   = 12;
  localparam int          NUM_RANDOM  = 40;
  localparam int unsigned MAX_CYCLES  = 4000;
  localparam int          DRIVE_DELAY = 2;
  // Smallest offset above the word index bits
  localparam word_t       ALIAS_STEP  = word_t'(1) << (RAM_AW + 2);

  logic  clk_i;
  logic  rst_n;
  logic  mem_valid_i;
  strb_t mem_wstrb_i;
  word_t mem_addr_i;
  word_t mem_wdata_i;
  logic  mem_ready_o;
  word_t mem_rdata_o;

  integer            seed;
  int unsigned       cycle_count = 0;
  logic [RAM_AW-1:0] word_idx [NUM_WORDS];

  tb_clock_gen u_clk (
    .clk_o   (clk_i),
    .rst_n_o (rst_n)
  );

  iomem_fabric_top dut (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .mem_valid_i (mem_valid_i),
    .mem_wstrb_i (mem_wstrb_i),
    .mem_addr_i  (mem_addr_i),
    .mem_wdata_i (mem_wdata_i),
    .mem_ready_o (mem_ready_o),
    .mem_rdata_o (mem_rdata_o)
  );

  function automatic word_t next_random();
    return $random(seed);
  endfunction

  function automatic word_t ram_addr(input logic [RAM_AW-1:0] idx, input word_t high_ofs);
    return RAM_BASE_ADDR | high_ofs | word_t'({idx, 2'b00});
  endfunction

  ////////////////////
  // Bus master
  ////////////////////

  // Entered and left 2 ns after a rising edge
  task automatic bus_access(input word_t addr, input strb_t strb, input word_t wdata);
    mem_valid_i = 1'b1;
    mem_addr_i  = addr;
    mem_wstrb_i = strb;
    mem_wdata_i = wdata;
    @(negedge clk_i);
    while (!mem_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #DRIVE_DELAY;
    mem_valid_i = 1'b0;
    mem_wstrb_i = '0;
    @(posedge clk_i);
    #DRIVE_DELAY;
  endtask

  task automatic write_word(input word_t addr, input strb_t strb, input word_t wdata);
    bus_access(addr, strb, wdata);
  endtask

  task automatic read_word(input word_t addr);
    bus_access(addr, 4'h0, next_random());
  endtask

  ////////////////////
  // Test steps
  ////////////////////

  task automatic timer_accesses();
    read_word(TIMER_LO_ADDR);
    read_word(TIMER_HI_ADDR);
    write_word(TIMER_LO_ADDR, 4'hf, next_random());
    write_word(TIMER_HI_ADDR, 4'hf, next_random());
    read_word(TIMER_LO_ADDR);
  endtask

  task automatic fill_words();
    word_t r;
    for (int i = 0; i < NUM_WORDS; i++) begin
      r = next_random();
      word_idx[i] = r[RAM_AW-1:0];
      write_word(ram_addr(word_idx[i], '0), 4'hf, next_random());
    end
    // Middle lanes only
    // Outer bytes keep their old value
    write_word(ram_addr(word_idx[0], '0), 4'b0110, next_random());
    read_word(ram_addr(word_idx[0], '0));
  endtask

  task automatic random_traffic();
    word_t r;
    int    k;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      r = next_random();
      k = int'(r[7:0]) % NUM_WORDS;
      if (r[8]) begin
        write_word(ram_addr(word_idx[k], '0), r[15:12], next_random());
      end else begin
        read_word(ram_addr(word_idx[k], '0));
      end
    end
  endtask

  task automatic alias_write_read();
    write_word(ram_addr(word_idx[2], ALIAS_STEP * 3), 4'hf, next_random());
    read_word(ram_addr(word_idx[2], '0));
    read_word(ram_addr(word_idx[2], ALIAS_STEP));
  endtask

  task automatic unmapped_accesses();
    write_word(32'h5000_0000 | word_t'({word_idx[1], 2'b00}), 4'hf, next_random());
    read_word(32'h3000_0008);
    read_word(32'h0000_0100);
    read_word(ram_addr(word_idx[1], '0));
  endtask

  task automatic readback_words();
    for (int i = 0; i < NUM_WORDS; i++) begin
      read_word(ram_addr(word_idx[i], '0));
    end
  endtask

  ////////////////////
  // Run control
  ////////////////////

  initial begin
    seed        = 32'h0c59_502a;
    mem_valid_i = 1'b0;
    mem_wstrb_i = '0;
    mem_addr_i  = '0;
    mem_wdata_i = '0;
    wait (rst_n === 1'b1);
    // Leave the first cycle after release idle
    @(posedge clk_i);
    #DRIVE_DELAY;
    timer_accesses();
    fill_words();
    random_traffic();
    alias_write_read();
    unmapped_accesses();
    readback_words();
    read_word(TIMER_HI_ADDR);
    repeat (2) @(posedge clk_i);
    // Let the assertions of this edge settle
    #DRIVE_DELAY;
    if (dut.u_chk.failed) begin
      $display("Verification failed");
      $fatal(1, "Bound checker reported a mismatch");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

  // Stop at the first failed assertion
  always @(negedge clk_i) begin
    if (dut.u_chk.failed) begin
      $display("Verification failed");
      $fatal(1, "Bound checker reported a mismatch");
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the test list did not finish within %0d cycles", MAX_CYCLES);
      $display("Verification failed");
      $fatal(1, "Simulation stopped by the cycle limit");
    end
  end

endmodule

/* list.f */
design/mem_map_pkg.sv
design/iomem_pkg.sv
design/iomem_req_if.sv
design/addr_decoder.sv
design/latency_ram.sv
design/response_unit.sv
design/iomem_fabric_top.sv
verif/tb_clock_gen.sv
verif/iomem_fabric_chk.sv
verif/iomem_fabric_tb.sv

/* Makefile */
TOP = iomem_fabric_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) \
		--Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
